// File: all.f
spi_pkg.sv
spi_edge_detect.sv
spi_slave_rx.sv
spi_master.sv
spi_loopback_top.sv
spi_assertions.sv
tb_spi_loopback.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run the simulation and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_spi_loopback -f all.f -o sim_spi_loopback || exit 1
./obj_dir/sim_spi_loopback +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: spi_assertions.sv
`timescale 1ns/100ps

module spi_assertions (
   input logic                sclk,
   input logic                rst,
   input logic                busy,
   input logic                done,
   input logic                slave_valid,
   input spi_pkg::spi_lines_t lines,
   input logic                cpol
);

   int   fail_cnt = 0;
   logic busy_q;
   logic frame_open;

   // Open from the rise of busy until the slave reports its word
   always_ff @(posedge sclk or posedge rst) begin
      if (rst) begin
         busy_q     <= 1'b0;
         frame_open <= 1'b0;
      end else begin
         busy_q <= busy;
         if (busy && !busy_q) begin
            frame_open <= 1'b1;
         end else if (slave_valid) begin
            frame_open <= 1'b0;
         end
      end
   end

   cs_idle_check: assert property (@(posedge sclk) disable iff (rst) !busy |-> lines.cs_n)
      else begin
         $error("chip select low while the master is idle");
         fail_cnt++;
      end

   // Serial clock rests at the polarity level between frames
   clk_idle_check: assert property (@(posedge sclk) disable iff (rst)
                                    lines.cs_n |-> (lines.spi_clk == cpol))
      else begin
         $error("serial clock off its idle level");
         fail_cnt++;
      end

   done_pulse_check: assert property (@(posedge sclk) disable iff (rst) done |=> !done)
      else begin
         $error("done held longer than one cycle");
         fail_cnt++;
      end

   valid_frame_check: assert property (@(posedge sclk) disable iff (rst)
                                       $rose(slave_valid) |-> (busy || frame_open))
      else begin
         $error("slave_valid without a pending frame");
         fail_cnt++;
      end

endmodule

bind spi_loopback_top spi_assertions u_spi_assertions (
   .sclk        (sclk),
   .rst         (rst),
   .busy        (busy),
   .done        (done),
   .slave_valid (slave_valid),
   .lines       (lines),
   .cpol        (u_spi_master.mode_reg[1])
);

// File: spi_edge_detect.sv
`timescale 1ns/100ps

module spi_edge_detect (
   input  logic                sclk,
   input  logic                rst,
   input  spi_pkg::spi_lines_t lines,
   input  spi_pkg::spi_mode_t  mode,
   output logic                sample,
   output logic                shift,
   output logic                frame_start,
   output logic                frame_end,
   output logic                mosi_sync
);
   import spi_pkg::*;

   spi_lines_t meta_q;
   spi_lines_t sync_q;
   logic       last_clk;
   logic       last_cs_n;
   logic       clk_rise;
   logic       clk_fall;
   logic       in_frame;
   logic       leading;
   logic       trailing;

   // Two flops per line, then one more for edge detection
   always_ff @(posedge sclk or posedge rst) begin
      if (rst) begin
         meta_q    <= spi_lines_idle;
         sync_q    <= spi_lines_idle;
         last_clk  <= 1'b0;
         last_cs_n <= 1'b1;
      end else begin
         meta_q    <= lines;
         sync_q    <= meta_q;
         last_clk  <= sync_q.spi_clk;
         last_cs_n <= sync_q.cs_n;
      end
   end

   assign clk_rise = sync_q.spi_clk && !last_clk;
   assign clk_fall = !sync_q.spi_clk && last_clk;

   // Selected on both sides of the edge, which masks idle level changes
   assign in_frame = !sync_q.cs_n && !last_cs_n;

   // Polarity picks which direction leads
   assign leading  = mode[1] ? clk_fall : clk_rise;
   assign trailing = mode[1] ? clk_rise : clk_fall;

   assign sample = in_frame && (mode[0] ? trailing : leading);
   assign shift  = in_frame && (mode[0] ? leading : trailing);

   assign frame_start = last_cs_n && !sync_q.cs_n;
   assign frame_end   = !last_cs_n && sync_q.cs_n;
   assign mosi_sync   = sync_q.mosi;

endmodule

// File: spi_input.txt
// Columns: mode, tx_word, expected slave_word, expected rx_word, extra start flag
// All hex; expected rx_word is the tx_word of the previous frame, 00 after reset
// A flag of 01 sends a second start while the master is busy
00 a5 a5 00 00
00 3c 3c a5 00
01 81 81 3c 00
01 7e 7e 81 01
02 ff ff 7e 00
02 00 00 ff 00
03 5a 5a 00 01
03 c3 c3 5a 00
00 01 01 c3 01
03 80 80 01 00
01 96 96 80 00
02 69 69 96 01
00 f0 f0 69 00
02 0f 0f f0 00
01 33 33 0f 01
03 cc cc 33 00
00 e7 e7 cc 00
01 18 18 e7 01
02 b2 b2 18 00
03 4d 4d b2 00

// File: spi_loopback_top.sv
`timescale 1ns/100ps

module spi_loopback_top (
   input  logic               sclk,
   input  logic               rst,
   input  spi_pkg::spi_mode_t mode,
   input  logic               start,
   input  spi_pkg::spi_word_t tx_word,
   output logic               busy,
   output logic               done,
   output spi_pkg::spi_word_t rx_word,
   output logic               slave_valid,
   output spi_pkg::spi_word_t slave_word
);
   import spi_pkg::*;

   // Internal SPI bus
   spi_lines_t lines;
   logic       miso;

   spi_master u_spi_master (
      .sclk    (sclk),
      .rst     (rst),
      .start   (start),
      .tx_word (tx_word),
      .mode    (mode),
      .lines   (lines),
      .miso    (miso),
      .busy    (busy),
      .done    (done),
      .rx_word (rx_word)
   );

   spi_slave_rx u_spi_slave_rx (
      .sclk        (sclk),
      .rst         (rst),
      .lines       (lines),
      .mode        (mode),
      .miso        (miso),
      .slave_valid (slave_valid),
      .slave_word  (slave_word)
   );

endmodule

// File: spi_master.sv
`timescale 1ns/100ps

module spi_master (
   input  logic                sclk,
   input  logic                rst,
   input  logic                start,
   input  spi_pkg::spi_word_t  tx_word,
   input  spi_pkg::spi_mode_t  mode,
   output spi_pkg::spi_lines_t lines,
   input  logic                miso,
   output logic                busy,
   output logic                done,
   output spi_pkg::spi_word_t  rx_word
);
   import spi_pkg::*;

   typedef enum logic [1:0] {st_idle, st_active, st_finish} state_type;

   state_type                 st_reg;
   spi_mode_t                 mode_reg;
   spi_lines_t                lines_reg;
   logic [half_cnt_width-1:0] half_cnt;
   logic [edge_cnt_width-1:0] edge_cnt;
   logic                      done_reg;
   spi_word_t                 tx_shift;
   spi_word_t                 rx_shift;
   spi_word_t                 rx_word_reg;
   logic                      accept;
   logic                      frame_over;
   logic                      half_end;
   logic                      sample_edge;

   // Requests are only taken while idle
   assign accept = start && (st_reg == st_idle);

   // All 2 x word_width clock edges have been produced
   assign frame_over = (edge_cnt == edge_cnt_width'(2 * word_width));

   assign half_end = (st_reg == st_active) && !frame_over &&
                     (half_cnt == half_cnt_width'(spi_half_period - 1));

   // Edge about to be produced is leading when the count is even;
   // phase 0 samples on leading edges, phase 1 on trailing ones
   assign sample_edge = (edge_cnt[0] == mode_reg[0]);

   always_ff @(posedge sclk or posedge rst) begin
      if (rst) begin
         st_reg    <= st_idle;
         mode_reg  <= '0;
         lines_reg <= spi_lines_idle;
         half_cnt  <= '0;
         edge_cnt  <= '0;
         done_reg  <= 1'b0;
      end else begin
         done_reg <= 1'b0;
         case (st_reg)
            st_idle: begin
               lines_reg.spi_clk <= mode_reg[1];
               if (accept) begin
                  st_reg            <= st_active;
                  mode_reg          <= mode;
                  lines_reg.spi_clk <= mode[1];
                  lines_reg.cs_n    <= 1'b0;
                  // First bit is on the line as chip select falls
                  lines_reg.mosi    <= tx_word[word_width-1];
                  // Puts the first edge spi_half_period cycles after start
                  half_cnt          <= half_cnt_width'(1);
                  edge_cnt          <= '0;
               end
            end
            st_active: begin
               if (frame_over) begin
                  lines_reg.cs_n <= 1'b1;
                  st_reg         <= st_finish;
               end else if (half_end) begin
                  lines_reg.spi_clk <= ~lines_reg.spi_clk;
                  half_cnt          <= '0;
                  edge_cnt          <= edge_cnt + 1'b1;
                  if (!sample_edge) begin
                     lines_reg.mosi <= tx_shift[word_width-1];
                  end
               end else begin
                  half_cnt <= half_cnt + 1'b1;
               end
            end
            st_finish: begin
               done_reg <= 1'b1;
               st_reg   <= st_idle;
            end
            default: begin
               st_reg <= st_idle;
            end
         endcase
      end
   end

   // Data path
   always_ff @(posedge sclk) begin
      if (accept) begin
         // Phase 1 re-presents the MSB on its first shift edge
         tx_shift <= mode[0] ? tx_word : tx_word << 1;
      end else if (half_end && !sample_edge) begin
         tx_shift <= tx_shift << 1;
      end
      if (half_end && sample_edge) begin
         rx_shift <= {rx_shift[word_width-2:0], miso};
      end
      if (st_reg == st_finish) begin
         rx_word_reg <= rx_shift;
      end
   end

   assign lines   = lines_reg;
   assign busy    = (st_reg != st_idle);
   assign done    = done_reg;
   assign rx_word = rx_word_reg;

endmodule

// File: spi_pkg.sv
package spi_pkg;

   // Frame size and serial clock timing
   localparam int word_width = 8;
   localparam int spi_half_period = 4;

   // Counter widths derived from the frame timing
   localparam int bit_cnt_width = $clog2(word_width);
   localparam int half_cnt_width = $clog2(spi_half_period);
   localparam int edge_cnt_width = $clog2(2 * word_width + 1);

   typedef logic [word_width-1:0] spi_word_t;

   // Bit 1 is clock polarity, bit 0 is clock phase
   typedef logic [1:0] spi_mode_t;

   // Lines driven by the master
   typedef struct packed {
      logic spi_clk;
      logic cs_n;
      logic mosi;
   } spi_lines_t;

   // Bus state with nothing selected and the clock low
   localparam spi_lines_t spi_lines_idle = '{spi_clk: 1'b0, cs_n: 1'b1, mosi: 1'b0};

endpackage

// File: spi_slave_rx.sv
`timescale 1ns/100ps

module spi_slave_rx (
   input  logic                sclk,
   input  logic                rst,
   input  spi_pkg::spi_lines_t lines,
   input  spi_pkg::spi_mode_t  mode,
   output logic                miso,
   output logic                slave_valid,
   output spi_pkg::spi_word_t  slave_word
);
   import spi_pkg::*;

   typedef enum logic {st_idle, st_sample} state_type;

   state_type                st_reg;
   state_type                st_nxt;
   logic [bit_cnt_width-1:0] cnt_reg;
   logic [bit_cnt_width-1:0] cnt_nxt;
   spi_word_t                din_reg;
   spi_word_t                din_nxt;
   spi_word_t                word_reg;
   spi_mode_t                mode_reg;
   logic                     miso_reg;
   logic                     valid_reg;
   logic                     sample_stb;
   logic                     shift_stb;
   logic                     frame_start;
   logic                     frame_end;
   logic                     mosi_sync;
   logic                     last_bit;

   spi_edge_detect u_spi_edge_detect (
      .sclk        (sclk),
      .rst         (rst),
      .lines       (lines),
      .mode        (mode_reg),
      .sample      (sample_stb),
      .shift       (shift_stb),
      .frame_start (frame_start),
      .frame_end   (frame_end),
      .mosi_sync   (mosi_sync)
   );

   assign last_bit = (cnt_reg == bit_cnt_width'(word_width - 1));
   assign din_nxt  = {din_reg[word_width-2:0], mosi_sync};

   always_comb begin
      st_nxt  = st_reg;
      cnt_nxt = cnt_reg;
      case (st_reg)
         st_idle: begin
            if (frame_start) begin
               st_nxt  = st_sample;
               cnt_nxt = '0;
            end
         end
         st_sample: begin
            // Early chip select rise drops the partial word
            if (frame_end) begin
               st_nxt  = st_idle;
               cnt_nxt = '0;
            end else if (sample_stb) begin
               cnt_nxt = last_bit ? '0 : cnt_reg + 1'b1;
            end
         end
         default: begin
            st_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge sclk or posedge rst) begin
      if (rst) begin
         st_reg    <= st_idle;
         cnt_reg   <= '0;
         din_reg   <= '0;
         word_reg  <= '0;
         mode_reg  <= '0;
         miso_reg  <= 1'b0;
         valid_reg <= 1'b0;
      end else begin
         st_reg    <= st_nxt;
         cnt_reg   <= cnt_nxt;
         valid_reg <= 1'b0;
         // Mode is frozen for the length of a frame
         if (st_reg == st_idle) begin
            mode_reg <= mode;
         end
         if (st_reg == st_sample && sample_stb) begin
            din_reg <= din_nxt;
            if (last_bit) begin
               valid_reg <= 1'b1;
               word_reg  <= din_nxt;
            end
         end
         // Echo bit follows the register MSB between frames and on shift edges
         if (st_reg == st_idle || shift_stb) begin
            miso_reg <= din_reg[word_width-1];
         end
      end
   end

   assign miso        = miso_reg;
   assign slave_valid = valid_reg;
   assign slave_word  = word_reg;

endmodule

// File: tb_spi_loopback.sv
`timescale 1ns/100ps

module tb_spi_loopback;
   import spi_pkg::*;

   localparam int num_vectors = 20;
   localparam int num_fields = 5;
   localparam int frame_cycles = 2 * spi_half_period * word_width + 2;
   localparam int max_cycles = num_vectors * (2 * spi_half_period * word_width + 10) + 100;

   logic       sclk;
   logic       rst;
   spi_mode_t  mode;
   logic       start;
   spi_word_t  tx_word;
   logic       busy;
   logic       done;
   spi_word_t  rx_word;
   logic       slave_valid;
   spi_word_t  slave_word;

   // Five bytes per frame for mode, tx_word, expected slave_word, expected rx_word and extra start
   logic [7:0] vec_mem [0:num_vectors*num_fields-1];

   int unsigned cycle_cnt = 0;
   int unsigned accept_cycle = 0;
   int          done_cnt = 0;
   int          valid_cnt = 0;
   int          mismatch_cnt = 0;
   int          fail_cnt = 0;
   int          assert_cnt;
   spi_word_t   exp_slave;
   spi_word_t   exp_rx;
   string       test_name = "reset";

   spi_loopback_top u_spi_loopback_top (
      .sclk        (sclk),
      .rst         (rst),
      .mode        (mode),
      .start       (start),
      .tx_word     (tx_word),
      .busy        (busy),
      .done        (done),
      .rx_word     (rx_word),
      .slave_valid (slave_valid),
      .slave_word  (slave_word)
   );

   initial sclk = 1'b0;
   always #10 sclk = ~sclk;

   // Run limit scales with the number of frames
   always @(posedge sclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Timeout after %0d cycles, %0d done and %0d slave_valid strobes seen",
                  cycle_cnt, done_cnt, valid_cnt);
         $display("Test failed");
         $finish;
      end
   end

   task automatic compare_word(input string what, input spi_word_t expected,
                               input spi_word_t actual);
      if (actual !== expected) begin
         mismatch_cnt++;
         $display("mismatch %s: %s expected %02h actual %02h",
                  test_name, what, expected, actual);
      end
   endtask

   // Outputs are sampled mid-cycle away from the rising edge
   always @(negedge sclk) begin
      if (!rst) begin
         if (start && !busy) begin
            accept_cycle = cycle_cnt;
         end
         if (done) begin
            done_cnt++;
            compare_word("rx_word", exp_rx, rx_word);
            if (cycle_cnt - accept_cycle != frame_cycles) begin
               mismatch_cnt++;
               $display("mismatch %s: done latency expected %0d actual %0d",
                        test_name, frame_cycles, cycle_cnt - accept_cycle);
            end
         end
         if (slave_valid) begin
            valid_cnt++;
            compare_word("slave_word", exp_slave, slave_word);
         end
      end
   end

   task automatic verify_idle_bus();
      if (u_spi_loopback_top.lines.cs_n !== 1'b1) begin
         fail_cnt++;
         $display("Chip select is not high after reset");
      end
      // Reset mode is 0, so the serial clock idles low
      if (u_spi_loopback_top.lines.spi_clk !== 1'b0) begin
         fail_cnt++;
         $display("Serial clock is not at its idle level after reset");
      end
      if (busy !== 1'b0 || done !== 1'b0 || slave_valid !== 1'b0) begin
         fail_cnt++;
         $display("busy, done or slave_valid is not low after reset");
      end
      compare_word("slave_word", '0, slave_word);
   endtask

   task automatic wait_for_results(input int count);
      while (done_cnt < count || valid_cnt < count) begin
         @(posedge sclk);
      end
      repeat (2) @(posedge sclk);
   endtask

   task automatic run_frame(input int idx);
      int         base;
      logic [7:0] extra;
      base      = idx * num_fields;
      extra     = vec_mem[base+4];
      exp_slave = vec_mem[base+2];
      exp_rx    = vec_mem[base+3];
      test_name = $sformatf("frame %0d mode %0d", idx, vec_mem[base][1:0]);
      @(posedge sclk);
      mode    <= vec_mem[base][1:0];
      tx_word <= vec_mem[base+1];
      start   <= 1'b1;
      @(posedge sclk);
      start <= 1'b0;
      if (extra != 8'h00) begin
         // Second request mid-frame with a different word
         repeat (12) @(posedge sclk);
         tx_word <= ~vec_mem[base+1];
         start   <= 1'b1;
         @(posedge sclk);
         start <= 1'b0;
      end
      wait_for_results(idx + 1);
   endtask

   initial begin
      rst     = 1'b1;
      start   = 1'b0;
      mode    = '0;
      tx_word = '0;
      $readmemh("spi_input.txt", vec_mem);
      repeat (3) @(posedge sclk);
      rst <= 1'b0;
      repeat (4) @(negedge sclk);
      verify_idle_bus();
      for (int i = 0; i < num_vectors; i++) begin
         run_frame(i);
      end
      repeat (10) @(posedge sclk);
      test_name = "strobe count";
      if (done_cnt != num_vectors) begin
         mismatch_cnt++;
         $display("mismatch %s: done strobes expected %0d actual %0d",
                  test_name, num_vectors, done_cnt);
      end
      if (valid_cnt != num_vectors) begin
         mismatch_cnt++;
         $display("mismatch %s: slave_valid strobes expected %0d actual %0d",
                  test_name, num_vectors, valid_cnt);
      end
      assert_cnt = u_spi_loopback_top.u_spi_assertions.fail_cnt;
      $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_cnt, fail_cnt, assert_cnt);
      if (mismatch_cnt + fail_cnt + assert_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
